//--- logic/md_consts.svh
`ifndef MD_CONSTS_SVH
`define MD_CONSTS_SVH

`define MD_WORD_BITS 32
`define MD_STEPS 32

`define MD_ADDR_OPA 8'h00
`define MD_ADDR_OPB 8'h04
`define MD_ADDR_CTRL 8'h08
`define MD_ADDR_STATUS 8'h0C
`define MD_ADDR_LO 8'h10
`define MD_ADDR_HI 8'h14

`endif

//--- logic/md_types_pkg.sv
`default_nettype none

`include "md_consts.svh"

package md_types_pkg;

   typedef logic [`MD_WORD_BITS-1:0] word_t;
   typedef logic [2*`MD_WORD_BITS-1:0] dword_t; // shifted copies, product
   typedef logic [$clog2(`MD_STEPS+1)-1:0] step_t; // remaining steps

   // bit 1 picks the divider, bit 0 means signed
   typedef enum logic [1:0] {
      op_multu = 2'd0,
      op_mult = 2'd1,
      op_divu = 2'd2,
      op_div = 2'd3
   } md_op_t;

   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_done
   } engine_state_t;

endpackage

`default_nettype wire

//--- logic/md_regs_pkg.sv
`default_nettype none

package md_regs_pkg;

   typedef logic [7:0] apb_addr_t;

   // register block side of the engine handshake
   typedef enum logic {
      hs_idle,
      hs_wait
   } host_state_t;

endpackage

`default_nettype wire

//--- logic/md_engine_if.sv
`timescale 1ns/1ps
`default_nettype none

interface md_engine_if import md_types_pkg::*; ();

   logic start; // one-cycle launch pulse
   logic sign;
   word_t op_a;
   word_t op_b;
   logic busy;
   logic done; // results valid this cycle only
   word_t res_lo;
   word_t res_hi;

   modport host (
      output start, sign, op_a, op_b,
      input busy, done, res_lo, res_hi
   );

   modport engine (
      input start, sign, op_a, op_b,
      output busy, done, res_lo, res_hi
   );

endinterface

`default_nettype wire

//--- logic/seq_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module seq_divider import md_types_pkg::*; (
   input logic clk,
   input logic resetn,
   md_engine_if.engine eng
);

   localparam int msb = 2*`MD_WORD_BITS - 1;

   engine_state_t state;
   step_t steps_left;
   dword_t rem_q; // dividend copy, ends as remainder
   dword_t dsr_q; // divisor copy, halved each step
   word_t quo_q;
   logic neg_quo;
   logic neg_rem;
   dword_t diff;
   word_t a_mag;
   word_t b_mag;
   word_t rem_w;

   assign a_mag = (eng.sign && eng.op_a[`MD_WORD_BITS-1]) ? -eng.op_a : eng.op_a;
   assign b_mag = (eng.sign && eng.op_b[`MD_WORD_BITS-1]) ? -eng.op_b : eng.op_b;
   assign diff = rem_q - dsr_q;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state <= st_idle;
         steps_left <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (eng.start) begin
                  state <= st_run;
                  steps_left <= step_t'(`MD_STEPS);
               end
            end
            st_run: begin
               steps_left <= steps_left - 1'b1;
               if (steps_left == step_t'(1)) begin
                  state <= st_done;
               end
            end
            st_done: state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && eng.start) begin
         rem_q <= {{`MD_WORD_BITS{1'b0}}, a_mag};
         dsr_q <= {1'b0, b_mag, {(`MD_WORD_BITS-1){1'b0}}}; // divisor at 62:31
         quo_q <= '0;
         // quotient sign from both operands, remainder follows the dividend
         neg_quo <= eng.sign && (eng.op_a[`MD_WORD_BITS-1] ^ eng.op_b[`MD_WORD_BITS-1]);
         neg_rem <= eng.sign && eng.op_a[`MD_WORD_BITS-1];
      end else if (state == st_run) begin
         if (!diff[msb]) begin
            rem_q <= diff; // restore by not taking it
         end
         quo_q <= {quo_q[`MD_WORD_BITS-2:0], ~diff[msb]};
         dsr_q <= dsr_q >> 1;
      end
   end

   assign rem_w = rem_q[`MD_WORD_BITS-1:0];

   assign eng.busy = (state != st_idle);
   assign eng.done = (state == st_done);
   assign eng.res_lo = neg_quo ? -quo_q : quo_q;
   assign eng.res_hi = neg_rem ? -rem_w : rem_w;

endmodule

`default_nettype wire

//--- logic/seq_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module seq_multiplier import md_types_pkg::*; (
   input logic clk,
   input logic resetn,
   md_engine_if.engine eng
);

   engine_state_t state;
   step_t steps_left;
   dword_t prod_q;
   dword_t mcand_q; // shifted left each step
   word_t mplier_q; // shifted right each step
   logic neg_q;
   word_t a_mag;
   word_t b_mag;
   dword_t prod_fix;

   assign a_mag = (eng.sign && eng.op_a[`MD_WORD_BITS-1]) ? -eng.op_a : eng.op_a;
   assign b_mag = (eng.sign && eng.op_b[`MD_WORD_BITS-1]) ? -eng.op_b : eng.op_b;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state <= st_idle;
         steps_left <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (eng.start) begin
                  state <= st_run;
                  steps_left <= step_t'(`MD_STEPS);
               end
            end
            st_run: begin
               steps_left <= steps_left - 1'b1;
               if (steps_left == step_t'(1)) begin
                  state <= st_done;
               end
            end
            st_done: state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && eng.start) begin
         prod_q <= '0;
         mcand_q <= {{`MD_WORD_BITS{1'b0}}, a_mag};
         mplier_q <= b_mag;
         neg_q <= eng.sign && (eng.op_a[`MD_WORD_BITS-1] ^ eng.op_b[`MD_WORD_BITS-1]);
      end else if (state == st_run) begin
         if (mplier_q[0]) begin
            prod_q <= prod_q + mcand_q;
         end
         mcand_q <= mcand_q << 1;
         mplier_q <= mplier_q >> 1;
      end
   end

   assign prod_fix = neg_q ? -prod_q : prod_q; // sign fixed on the full 64 bits

   assign eng.busy = (state != st_idle);
   assign eng.done = (state == st_done);
   assign eng.res_lo = prod_fix[`MD_WORD_BITS-1:0];
   assign eng.res_hi = prod_fix[2*`MD_WORD_BITS-1:`MD_WORD_BITS];

endmodule

`default_nettype wire

//--- logic/md_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module md_apb_regs import md_types_pkg::*; import md_regs_pkg::*; (
   input logic clk,
   input logic resetn,
   input logic psel,
   input logic penable,
   input logic pwrite,
   input apb_addr_t paddr,
   input word_t pwdata,
   output word_t prdata,
   output logic pready,
   output logic pslverr,
   md_engine_if.host div_bus,
   md_engine_if.host mul_bus
);

   host_state_t state;
   md_op_t op_q;
   word_t opa_q;
   word_t opb_q;
   word_t lo_q;
   word_t hi_q;
   logic divzero_q;
   logic start_q;
   logic access;
   logic wr;
   logic busy;
   logic addr_ok;
   logic ctrl_wr;
   logic launch;
   logic done_any;

   assign access = psel && penable; // access phase
   assign wr = access && pwrite;
   assign busy = (state == hs_wait);
   assign ctrl_wr = wr && (paddr == `MD_ADDR_CTRL);
   assign launch = ctrl_wr && !busy;
   assign done_any = div_bus.done || mul_bus.done;

   assign pready = 1'b1;
   assign pslverr = access && (!addr_ok || (ctrl_wr && busy));

   always_comb begin
      addr_ok = 1'b1;
      prdata = '0;
      case (paddr)
         `MD_ADDR_OPA: prdata = opa_q;
         `MD_ADDR_OPB: prdata = opb_q;
         `MD_ADDR_CTRL: prdata = '0; // write only
         `MD_ADDR_STATUS: prdata = word_t'({divzero_q, busy});
         `MD_ADDR_LO: prdata = lo_q;
         `MD_ADDR_HI: prdata = hi_q;
         default: addr_ok = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state <= hs_idle;
         op_q <= op_multu;
         start_q <= 1'b0;
         opa_q <= '0;
         opb_q <= '0;
         lo_q <= '0;
         hi_q <= '0;
         divzero_q <= 1'b0;
      end else begin
         start_q <= launch;
         if (wr && paddr == `MD_ADDR_OPA) begin
            opa_q <= pwdata;
         end
         if (wr && paddr == `MD_ADDR_OPB) begin
            opb_q <= pwdata;
         end
         if (launch) begin
            op_q <= md_op_t'(pwdata[1:0]);
            state <= hs_wait;
            if (pwdata[1]) begin
               divzero_q <= (opb_q == '0); // only divisions update it
            end
         end else if (busy && done_any) begin
            lo_q <= div_bus.done ? div_bus.res_lo : mul_bus.res_lo;
            hi_q <= div_bus.done ? div_bus.res_hi : mul_bus.res_hi;
            state <= hs_idle;
         end
      end
   end

   // both engines see the operands, only one gets the pulse
   assign div_bus.start = start_q && op_q[1];
   assign div_bus.sign = op_q[0];
   assign div_bus.op_a = opa_q;
   assign div_bus.op_b = opb_q;

   assign mul_bus.start = start_q && !op_q[1];
   assign mul_bus.sign = op_q[0];
   assign mul_bus.op_a = opa_q;
   assign mul_bus.op_b = opb_q;

endmodule

`default_nettype wire

//--- logic/md_unit.sv
`timescale 1ns/1ps
`default_nettype none

module md_unit import md_types_pkg::*; import md_regs_pkg::*; (
   input logic clk,
   input logic resetn,
   input logic psel,
   input logic penable,
   input logic pwrite,
   input apb_addr_t paddr,
   input word_t pwdata,
   output word_t prdata,
   output logic pready,
   output logic pslverr
);

   md_engine_if div_bus ();
   md_engine_if mul_bus ();

   md_apb_regs regs_i (
      .clk (clk),
      .resetn (resetn),
      .psel (psel),
      .penable (penable),
      .pwrite (pwrite),
      .paddr (paddr),
      .pwdata (pwdata),
      .prdata (prdata),
      .pready (pready),
      .pslverr (pslverr),
      .div_bus (div_bus.host),
      .mul_bus (mul_bus.host)
   );

   seq_divider div_i (
      .clk (clk),
      .resetn (resetn),
      .eng (div_bus.engine)
   );

   seq_multiplier mul_i (
      .clk (clk),
      .resetn (resetn),
      .eng (mul_bus.engine)
   );

endmodule

`default_nettype wire

//--- tests/md_unit_props.sv
`timescale 1ns/1ps
`default_nettype none

module md_unit_props (
   input logic clk,
   input logic resetn,
   input logic div_start,
   input logic div_busy,
   input logic div_done,
   input logic mul_start,
   input logic mul_busy,
   input logic mul_done,
   input logic pready
);

   div_start_idle: assert property (@(posedge clk) disable iff (!resetn)
      !(div_start && div_busy)) else $error("divider started while busy");

   mul_start_idle: assert property (@(posedge clk) disable iff (!resetn)
      !(mul_start && mul_busy)) else $error("multiplier started while busy");

   // engine goes back to idle right after done
   div_done_release: assert property (@(posedge clk) disable iff (!resetn)
      div_done |=> !div_busy) else $error("divider still busy after done");

   mul_done_release: assert property (@(posedge clk) disable iff (!resetn)
      mul_done |=> !mul_busy) else $error("multiplier still busy after done");

   no_wait_states: assert property (@(posedge clk) pready)
      else $error("pready low");

endmodule

bind md_unit md_unit_props props_i (
   .clk (clk),
   .resetn (resetn),
   .div_start (div_bus.start),
   .div_busy (div_bus.busy),
   .div_done (div_bus.done),
   .mul_start (mul_bus.start),
   .mul_busy (mul_bus.busy),
   .mul_done (mul_bus.done),
   .pready (pready)
);

`default_nettype wire

//--- tests/md_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module md_unit_tb import md_types_pkg::*; import md_regs_pkg::*; ();

   localparam word_t corners [0:6] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF,
      32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFF9, 32'h0000_000D};

   logic clk;
   logic resetn;
   logic psel;
   logic penable;
   logic pwrite;
   apb_addr_t paddr;
   word_t pwdata;
   word_t prdata;
   logic pready;
   logic pslverr;

   md_unit md_unit_i (
      .clk (clk),
      .resetn (resetn),
      .psel (psel),
      .penable (penable),
      .pwrite (pwrite),
      .paddr (paddr),
      .pwdata (pwdata),
      .prdata (prdata),
      .pready (pready),
      .pslverr (pslverr)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk; // 40 ns period

   task automatic report_mismatch(input string msg);
      $display("ERR %0t: %s", $time, msg);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at %0t: %s did not finish in time", $time, what);
      $display("Test FAILED");
      $fatal(1, "timeout");
   endtask

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_err(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         report_mismatch($sformatf("%s: pslverr %b, expected %b", what, got, exp));
      end
   endtask

   task automatic check_ready(input string what, input logic got);
      if (got !== 1'b1) begin
         report_mismatch($sformatf("%s: pready %b, expected 1", what, got));
      end
   endtask

   task automatic check_status(input word_t got, input logic exp_busy, input logic exp_divzero);
      if (got[0] !== exp_busy || got[1] !== exp_divzero) begin
         report_mismatch($sformatf("status %h: expected busy %b divzero %b",
            got, exp_busy, exp_divzero));
      end
   endtask

   task automatic apb_write(input apb_addr_t addr, input word_t data, input logic exp_err);
      @(posedge clk);
      psel <= 1'b1; // setup phase
      penable <= 1'b0;
      pwrite <= 1'b1;
      paddr <= addr;
      pwdata <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      check_ready($sformatf("write %h", addr), pready);
      check_err($sformatf("write %h", addr), pslverr, exp_err);
      @(posedge clk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, input logic exp_err, output word_t data);
      @(posedge clk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= 1'b0;
      paddr <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      check_ready($sformatf("read %h", addr), pready);
      check_err($sformatf("read %h", addr), pslverr, exp_err);
      data = prdata;
      @(posedge clk);
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic start_op(input word_t a, input word_t b, input md_op_t op);
      apb_write(`MD_ADDR_OPA, a, 1'b0);
      apb_write(`MD_ADDR_OPB, b, 1'b0);
      apb_write(`MD_ADDR_CTRL, word_t'(op), 1'b0);
   endtask

   task automatic wait_idle();
      int polls;
      word_t st;
      polls = 0;
      apb_read(`MD_ADDR_STATUS, 1'b0, st);
      while (st[0]) begin
         polls++;
         if (polls > 100) begin
            report_timeout("operation");
         end
         apb_read(`MD_ADDR_STATUS, 1'b0, st);
      end
   endtask

   task automatic run_op(input word_t a, input word_t b, input md_op_t op,
                         output word_t lo, output word_t hi);
      start_op(a, b, op);
      wait_idle();
      apb_read(`MD_ADDR_LO, 1'b0, lo);
      apb_read(`MD_ADDR_HI, 1'b0, hi);
   endtask

   function automatic dword_t mul_expect(input word_t a, input word_t b, input logic signed_op);
      longint sa;
      longint sb;
      dword_t ua;
      dword_t ub;
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      ua = dword_t'(a);
      ub = dword_t'(b);
      if (signed_op) begin
         return dword_t'(sa * sb);
      end
      return ua * ub;
   endfunction

   // 64-bit math keeps the most negative dividend over -1 in range
   task automatic div_expect(input word_t a, input word_t b, input logic signed_op,
                             output word_t q, output word_t r);
      longint sa;
      longint sb;
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      if (b == '0) begin
         q = '1;
         r = a;
      end else if (signed_op) begin
         q = word_t'(sa / sb); // truncates toward zero
         r = word_t'(sa % sb);
      end else begin
         q = a / b;
         r = a % b;
      end
   endtask

   task automatic check_mul(input word_t a, input word_t b, input md_op_t op);
      word_t lo;
      word_t hi;
      dword_t exp;
      run_op(a, b, op, lo, hi);
      exp = mul_expect(a, b, op[0]);
      check_word($sformatf("%s %h*%h lo", op.name(), a, b), lo, exp[31:0]);
      check_word($sformatf("%s %h*%h hi", op.name(), a, b), hi, exp[63:32]);
   endtask

   task automatic check_div(input word_t a, input word_t b, input md_op_t op);
      word_t lo;
      word_t hi;
      word_t q;
      word_t r;
      run_op(a, b, op, lo, hi);
      div_expect(a, b, op[0], q, r);
      check_word($sformatf("%s %h/%h quotient", op.name(), a, b), lo, q);
      check_word($sformatf("%s %h/%h remainder", op.name(), a, b), hi, r);
   endtask

   task automatic reset_and_access();
      word_t rd;
      apb_read(`MD_ADDR_STATUS, 1'b0, rd);
      check_status(rd, 1'b0, 1'b0);
      apb_read(`MD_ADDR_LO, 1'b0, rd);
      check_word("lo after reset", rd, '0);
      apb_read(`MD_ADDR_HI, 1'b0, rd);
      check_word("hi after reset", rd, '0);
      apb_read(`MD_ADDR_OPA, 1'b0, rd);
      check_word("opa after reset", rd, '0);
      apb_write(`MD_ADDR_OPA, 32'h1234_5678, 1'b0);
      apb_write(`MD_ADDR_OPB, 32'hCAFE_F00D, 1'b0);
      apb_read(`MD_ADDR_OPA, 1'b0, rd);
      check_word("opa readback", rd, 32'h1234_5678);
      apb_read(`MD_ADDR_OPB, 1'b0, rd);
      check_word("opb readback", rd, 32'hCAFE_F00D);
      apb_read(`MD_ADDR_CTRL, 1'b0, rd);
      check_word("ctrl read", rd, '0);
      apb_read(8'h18, 1'b1, rd); // unmapped
      apb_write(8'h1C, 32'hFFFF_FFFF, 1'b1);
   endtask

   task automatic multiply_cases();
      for (int i = 0; i < 7; i++) begin
         for (int j = 0; j < 7; j++) begin
            check_mul(corners[i], corners[j], op_multu);
            check_mul(corners[i], corners[j], op_mult);
         end
      end
      for (int n = 0; n < 20; n++) begin
         check_mul($urandom, $urandom, op_multu);
         check_mul($urandom, $urandom, op_mult);
      end
   endtask

   task automatic divide_cases();
      word_t b;
      word_t bs;
      for (int i = 0; i < 7; i++) begin
         for (int j = 0; j < 7; j++) begin
            if (corners[j] == '0) continue;
            check_div(corners[i], corners[j], op_divu);
            check_div(corners[i], corners[j], op_div);
         end
      end
      for (int n = 0; n < 20; n++) begin
         b = $urandom;
         if (b == '0) b = 32'd3;
         bs = b >> (n % 24);
         if (bs == '0) bs = 32'd5;
         check_div($urandom, b, op_divu);
         check_div($urandom, bs, op_div);
      end
   endtask

   task automatic divide_by_zero();
      word_t st;
      check_div(32'h1234_5678, '0, op_divu);
      apb_read(`MD_ADDR_STATUS, 1'b0, st);
      check_status(st, 1'b0, 1'b1);
      check_mul(32'd3, 32'd5, op_multu); // multiply leaves the flag alone
      apb_read(`MD_ADDR_STATUS, 1'b0, st);
      check_status(st, 1'b0, 1'b1);
      check_div(32'd100, 32'd7, op_divu);
      apb_read(`MD_ADDR_STATUS, 1'b0, st);
      check_status(st, 1'b0, 1'b0);
   endtask

   task automatic back_pressure();
      word_t rd;
      check_mul(32'd6, 32'd7, op_multu);
      start_op(32'd1000, 32'd7, op_divu);
      apb_write(`MD_ADDR_CTRL, word_t'(op_mult), 1'b1); // rejected while busy
      apb_write(`MD_ADDR_OPA, 32'd5, 1'b0);
      apb_read(`MD_ADDR_STATUS, 1'b0, rd);
      check_status(rd, 1'b1, 1'b0);
      apb_read(`MD_ADDR_LO, 1'b0, rd);
      check_word("lo held while busy", rd, 32'd42);
      apb_read(`MD_ADDR_HI, 1'b0, rd);
      check_word("hi held while busy", rd, '0);
      wait_idle();
      apb_read(`MD_ADDR_LO, 1'b0, rd);
      check_word("quotient after opa rewrite", rd, 32'd142);
      apb_read(`MD_ADDR_HI, 1'b0, rd);
      check_word("remainder after opa rewrite", rd, 32'd6);
      apb_read(`MD_ADDR_OPA, 1'b0, rd);
      check_word("opa rewritten", rd, 32'd5);
   endtask

   initial begin
      void'($urandom(54));
      resetn <= 1'b0;
      psel <= 1'b0;
      penable <= 1'b0;
      pwrite <= 1'b0;
      paddr <= '0;
      pwdata <= '0;
      repeat (2) @(posedge clk);
      resetn <= 1'b1;
      reset_and_access();
      multiply_cases();
      divide_cases();
      divide_by_zero();
      back_pressure();
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- md_unit.f
+incdir+logic
logic/md_types_pkg.sv
logic/md_regs_pkg.sv
logic/md_engine_if.sv
logic/seq_divider.sv
logic/seq_multiplier.sv
logic/md_apb_regs.sv
logic/md_unit.sv
tests/md_unit_props.sv
tests/md_unit_tb.sv

//--- Makefile
SIM = obj_dir/md_unit_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build md_unit_tb with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f md_unit.f --top-module md_unit_tb -o md_unit_sim
	./$(SIM)

clean:
	rm -rf obj_dir
